/* source/obi_mux_cfg.svh */
/*
 * Build-time sizes of the OBI multiplexer. OBI_IDX_WIDTH must be clog2 of
 * OBI_NUM_PORTS, and the Hsiao columns in the package assume 2 index bits
 * with 4 check bits.
 */
`ifndef OBI_MUX_CFG_SVH
`define OBI_MUX_CFG_SVH

// Bus widths of the A and R channels.
`define OBI_ADDR_WIDTH 32
`define OBI_DATA_WIDTH 32

// Subordinate ports merged onto the single manager port.
`define OBI_NUM_PORTS 4
`define OBI_IDX_WIDTH 2

// Hsiao SEC-DED check bits that protect each stored port index.
`define OBI_IDX_ECC_WIDTH 4

// Depth of the response routing FIFO, which bounds the outstanding transactions.
`define OBI_MAX_TRANS 4

`endif

/* source/obi_mux_pkg.sv */
/*
 * Channel types and the Hsiao SEC-DED code for the stored port index.
 * The data columns are fixed for a 2-bit index and 4 check bits.
 */
`default_nettype none
`include "obi_mux_cfg.svh"

package obi_mux_pkg;

  localparam int unsigned idx_code_width = `OBI_IDX_WIDTH + `OBI_IDX_ECC_WIDTH;

  // Odd-weight columns of the check matrix for the index bits, weight 3.
  localparam logic [`OBI_IDX_WIDTH-1:0][`OBI_IDX_ECC_WIDTH-1:0] hsiao_data_cols = {
    4'b1011,
    4'b0111
  };

  typedef struct packed {
    logic [`OBI_ADDR_WIDTH-1:0]   addr;
    logic [`OBI_DATA_WIDTH-1:0]   wdata;
    logic                         we;
    logic [`OBI_DATA_WIDTH/8-1:0] be;
  } obi_a_chan_t;

  typedef struct packed {
    logic [`OBI_DATA_WIDTH-1:0] rdata;
    logic                       err;
  } obi_r_chan_t;

  typedef struct packed {
    logic        req;
    obi_a_chan_t a;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    obi_r_chan_t r;
  } obi_rsp_t;

  typedef struct packed {
    logic [`OBI_IDX_ECC_WIDTH-1:0] check;
    logic [`OBI_IDX_WIDTH-1:0]     idx;
  } idx_code_fields_t;

  // The FIFO stores the raw word, the router decodes it field by field.
  typedef union packed {
    logic [idx_code_width-1:0] bits;
    idx_code_fields_t          field;
  } idx_code_t;

  function automatic idx_code_t hsiao_encode(input logic [`OBI_IDX_WIDTH-1:0] idx);
    idx_code_t code;
    code.field.idx   = idx;
    code.field.check = '0;
    for (int i = 0; i < `OBI_IDX_WIDTH; i++) begin
      if (idx[i]) begin
        code.field.check = code.field.check ^ hsiao_data_cols[i];
      end
    end
    return code;
  endfunction

  // Zero for a clean word, a data column for a flipped index bit, weight 1 for a check bit.
  function automatic logic [`OBI_IDX_ECC_WIDTH-1:0] hsiao_syndrome(input idx_code_t code);
    idx_code_t expected;
    expected = hsiao_encode(code.field.idx);
    return expected.field.check ^ code.field.check;
  endfunction

endpackage

`default_nettype wire

/* source/obi_rr_arbiter.sv */
/*
 * Round-robin arbiter with lock-in. A subordinate must hold req and its A channel
 * until granted. The manager req is withheld while the routing FIFO is full.
 */
`timescale 1ns/100ps
`default_nettype none
`include "obi_mux_cfg.svh"

module obi_rr_arbiter (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  input  obi_mux_pkg::obi_req_t [`OBI_NUM_PORTS-1:0] sbr_req_i,
  output logic [`OBI_NUM_PORTS-1:0]                  sbr_gnt_o,
  input  logic                                       fifo_full_i,
  input  logic                                       mgr_gnt_i,
  output obi_mux_pkg::obi_req_t                      mgr_req_o,
  output logic [`OBI_IDX_WIDTH-1:0]                  sel_idx_o
);

  localparam logic [`OBI_IDX_WIDTH-1:0] last_idx = `OBI_IDX_WIDTH'(`OBI_NUM_PORTS - 1);

  logic [`OBI_NUM_PORTS-1:0] req_vec;
  logic [`OBI_IDX_WIDTH-1:0] rr_ptr_q;
  logic [`OBI_IDX_WIDTH-1:0] lock_idx_q;
  logic                      lock_q;
  logic [`OBI_IDX_WIDTH-1:0] search_idx;
  logic                      search_hit;
  logic [`OBI_IDX_WIDTH-1:0] sel_idx;
  logic [`OBI_IDX_WIDTH-1:0] next_ptr;
  logic                      sel_valid;
  logic                      handshake;

  always_comb begin
    for (int i = 0; i < `OBI_NUM_PORTS; i++) begin
      req_vec[i] = sbr_req_i[i].req;
    end
  end

  // Scan the ports starting at the priority pointer and wrap around once.
  always_comb begin : proc_search
    int unsigned cand;
    search_idx = rr_ptr_q;
    search_hit = 1'b0;
    for (int unsigned off = 0; off < `OBI_NUM_PORTS; off++) begin
      cand = rr_ptr_q + off;
      if (cand >= `OBI_NUM_PORTS) begin
        cand = cand - `OBI_NUM_PORTS;
      end
      if (!search_hit && req_vec[cand]) begin
        search_hit = 1'b1;
        search_idx = cand[`OBI_IDX_WIDTH-1:0];
      end
    end
  end

  // A pending choice stays put until its grant arrives.
  assign sel_idx   = lock_q ? lock_idx_q : search_idx;
  assign sel_valid = lock_q ? req_vec[lock_idx_q] : search_hit;
  assign sel_idx_o = sel_idx;

  assign mgr_req_o.req = sel_valid & ~fifo_full_i;
  assign mgr_req_o.a   = sbr_req_i[sel_idx].a;
  assign handshake     = mgr_req_o.req & mgr_gnt_i;

  always_comb begin
    sbr_gnt_o          = '0;
    sbr_gnt_o[sel_idx] = handshake;
  end

  assign next_ptr = (sel_idx == last_idx) ? '0 : sel_idx + 1'b1;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_ptr_q   <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (handshake) begin
      rr_ptr_q <= next_ptr;
      lock_q   <= 1'b0;
    end else if (sel_valid) begin
      // Also holds while the FIFO is full, so the A channel stays stable.
      lock_q     <= 1'b1;
      lock_idx_q <= sel_idx;
    end else begin
      lock_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* source/id_ecc_fifo.sv */
/*
 * In-order FIFO of Hsiao-encoded port indices, depth OBI_MAX_TRANS.
 * A push while full and a pop while empty are ignored. The head reads as
 * the all-zero codeword while the FIFO is empty.
 */
`timescale 1ns/100ps
`default_nettype none
`include "obi_mux_cfg.svh"

module id_ecc_fifo (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      push_i,
  input  logic [`OBI_IDX_WIDTH-1:0] idx_i,
  input  logic                      pop_i,
  output logic                      full_o,
  output logic                      empty_o,
  output obi_mux_pkg::idx_code_t    head_o
);

  import obi_mux_pkg::*;

  localparam int unsigned ptr_width = (`OBI_MAX_TRANS > 1) ? $clog2(`OBI_MAX_TRANS) : 1;
  localparam int unsigned cnt_width = $clog2(`OBI_MAX_TRANS + 1);
  localparam logic [ptr_width-1:0] last_slot = ptr_width'(`OBI_MAX_TRANS - 1);
  localparam logic [cnt_width-1:0] max_count = cnt_width'(`OBI_MAX_TRANS);

  logic [idx_code_width-1:0] mem_q [`OBI_MAX_TRANS];
  logic [ptr_width-1:0]      wr_ptr_q;
  logic [ptr_width-1:0]      rd_ptr_q;
  logic [cnt_width-1:0]      count_q;
  idx_code_t                 wr_code;
  logic                      do_push;
  logic                      do_pop;

  assign full_o  = (count_q == max_count);
  assign empty_o = (count_q == '0);

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  assign wr_code = hsiao_encode(idx_i);

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= wr_code.bits;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
    end else if (do_push) begin
      wr_ptr_q <= (wr_ptr_q == last_slot) ? '0 : wr_ptr_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_ptr_q <= '0;
    end else if (do_pop) begin
      rd_ptr_q <= (rd_ptr_q == last_slot) ? '0 : rd_ptr_q + 1'b1;
    end
  end

  // A push and a pop in the same cycle leave the count unchanged.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else begin
      case ({do_push, do_pop})
        2'b10: count_q <= count_q + 1'b1;
        2'b01: count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_comb begin
    if (empty_o) begin
      head_o.bits = '0;
    end else begin
      head_o.bits = mem_q[rd_ptr_q];
    end
  end

endmodule

`default_nettype wire

/* source/obi_rsp_router.sv */
/*
 * Steers each manager response to the port named by the FIFO head.
 * A response with an uncorrectable index, or with no entry in the FIFO, is
 * dropped and flagged on fault_o[1].
 */
`timescale 1ns/100ps
`default_nettype none
`include "obi_mux_cfg.svh"

module obi_rsp_router (
  input  obi_mux_pkg::idx_code_t    head_i,
  input  logic                      empty_i,
  input  obi_mux_pkg::obi_rsp_t     mgr_rsp_i,
  output logic [`OBI_NUM_PORTS-1:0] sbr_rvalid_o,
  output obi_mux_pkg::obi_r_chan_t  sbr_r_o,
  output logic                      pop_o,
  output logic [1:0]                fault_o
);

  import obi_mux_pkg::*;

  logic [`OBI_IDX_ECC_WIDTH-1:0] syndrome;
  logic [`OBI_IDX_WIDTH-1:0]     corr_idx;
  logic                          single_err;
  logic                          double_err;
  logic                          rsp_ok;

  assign syndrome = hsiao_syndrome(head_i);

  always_comb begin
    corr_idx   = head_i.field.idx;
    single_err = 1'b0;
    double_err = 1'b0;
    if (syndrome != '0) begin
      if ($countones(syndrome) == 1) begin
        // Flipped check bit, the index itself is intact.
        single_err = 1'b1;
      end else begin
        double_err = 1'b1;
        for (int i = 0; i < `OBI_IDX_WIDTH; i++) begin
          if (syndrome == hsiao_data_cols[i]) begin
            corr_idx[i] = ~corr_idx[i];
            single_err  = 1'b1;
            double_err  = 1'b0;
          end
        end
      end
    end
  end

  // Every manager response retires one FIFO entry.
  assign pop_o   = mgr_rsp_i.rvalid;
  assign sbr_r_o = mgr_rsp_i.r;

  assign rsp_ok = mgr_rsp_i.rvalid & ~empty_i & ~double_err;

  always_comb begin
    sbr_rvalid_o           = '0;
    sbr_rvalid_o[corr_idx] = rsp_ok;
  end

  assign fault_o[0] = mgr_rsp_i.rvalid & ~empty_i & single_err;
  assign fault_o[1] = mgr_rsp_i.rvalid & (empty_i | double_err);

endmodule

`default_nettype wire

/* source/obi_mux.sv */
/*
 * OBI multiplexer of OBI_NUM_PORTS subordinate ports onto one manager port.
 * The manager must answer in request order with one response per grant and
 * has no rready. fault_o is [1] uncorrectable, [0] corrected routing error.
 */
`timescale 1ns/100ps
`default_nettype none
`include "obi_mux_cfg.svh"

module obi_mux (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  input  obi_mux_pkg::obi_req_t [`OBI_NUM_PORTS-1:0] sbr_req_i,
  output obi_mux_pkg::obi_rsp_t [`OBI_NUM_PORTS-1:0] sbr_rsp_o,
  output obi_mux_pkg::obi_req_t                      mgr_req_o,
  input  obi_mux_pkg::obi_rsp_t                      mgr_rsp_i,
  output logic [1:0]                                 fault_o
);

  import obi_mux_pkg::*;

  logic [`OBI_NUM_PORTS-1:0] sbr_gnt;
  logic [`OBI_NUM_PORTS-1:0] sbr_rvalid;
  logic [`OBI_IDX_WIDTH-1:0] sel_idx;
  logic                      fifo_full;
  logic                      fifo_empty;
  logic                      push;
  logic                      pop;
  idx_code_t                 head_code;
  obi_r_chan_t               sbr_r;

  obi_rr_arbiter i_arbiter (
    .clk_i       ( clk_i         ),
    .rst_n_i     ( rst_n_i       ),
    .sbr_req_i   ( sbr_req_i     ),
    .sbr_gnt_o   ( sbr_gnt       ),
    .fifo_full_i ( fifo_full     ),
    .mgr_gnt_i   ( mgr_rsp_i.gnt ),
    .mgr_req_o   ( mgr_req_o     ),
    .sel_idx_o   ( sel_idx       )
  );

  // The index of the granted port is recorded on the accepted A handshake.
  assign push = mgr_req_o.req & mgr_rsp_i.gnt;

  id_ecc_fifo i_idx_fifo (
    .clk_i   ( clk_i      ),
    .rst_n_i ( rst_n_i    ),
    .push_i  ( push       ),
    .idx_i   ( sel_idx    ),
    .pop_i   ( pop        ),
    .full_o  ( fifo_full  ),
    .empty_o ( fifo_empty ),
    .head_o  ( head_code  )
  );

  obi_rsp_router i_router (
    .head_i       ( head_code  ),
    .empty_i      ( fifo_empty ),
    .mgr_rsp_i    ( mgr_rsp_i  ),
    .sbr_rvalid_o ( sbr_rvalid ),
    .sbr_r_o      ( sbr_r      ),
    .pop_o        ( pop        ),
    .fault_o      ( fault_o    )
  );

  // R channel goes to every port; only rvalid selects the receiver.
  always_comb begin
    for (int i = 0; i < `OBI_NUM_PORTS; i++) begin
      sbr_rsp_o[i].gnt    = sbr_gnt[i];
      sbr_rsp_o[i].rvalid = sbr_rvalid[i];
      sbr_rsp_o[i].r      = sbr_r;
    end
  end

endmodule

`default_nettype wire

/* tests/tb_clk_gen.sv */
/*
 * Testbench clock of 4 ns period. Reset is held low for 10 rising edges.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

/* tests/obi_mux_asserts.sv */
/*
 * Concurrent checks bound into every obi_mux instance. They sample the
 * subordinate requests, the internal grant, rvalid and pop nets by name, and
 * keep their own count of the transfers that still await a response.
 */
`timescale 1ns/100ps
`default_nettype none
`include "obi_mux_cfg.svh"

module obi_mux_asserts (
  input logic                                       clk_i,
  input logic                                       rst_n_i,
  input obi_mux_pkg::obi_req_t [`OBI_NUM_PORTS-1:0] sbr_req_i,
  input logic [`OBI_NUM_PORTS-1:0]                  gnt_i,
  input logic [`OBI_NUM_PORTS-1:0]                  rvalid_i,
  input logic                                       mgr_req_i,
  input logic                                       mgr_gnt_i,
  input logic                                       pop_i,
  input logic [1:0]                                 fault_i
);

  logic [`OBI_NUM_PORTS-1:0] req_vec;
  int                        outstanding_q;

  always_comb begin
    for (int i = 0; i < `OBI_NUM_PORTS; i++) begin
      req_vec[i] = sbr_req_i[i].req;
    end
  end

  // Accepted requests that still wait for their response.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      outstanding_q <= 0;
    end else begin
      outstanding_q <= outstanding_q + int'(mgr_req_i & mgr_gnt_i)
                       - int'(pop_i && outstanding_q > 0);
    end
  end

  gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(gnt_i) && ((gnt_i & ~req_vec) == '0))
    else $error("subordinate grant not one-hot or given to an idle port");

  req_low_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (outstanding_q >= `OBI_MAX_TRANS) |-> !mgr_req_i)
    else $error("manager request raised while the routing FIFO is full");

  rvalid_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(rvalid_i) && (rvalid_i == '0 || outstanding_q != 0))
    else $error("response routed to several subordinates or with none outstanding");

  fault_only_on_pop: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !pop_i |-> (fault_i == 2'b00))
    else $error("fault flag raised with no response popping");

endmodule

bind obi_mux obi_mux_asserts i_asserts (
  .clk_i     ( clk_i         ),
  .rst_n_i   ( rst_n_i       ),
  .sbr_req_i ( sbr_req_i     ),
  .gnt_i     ( sbr_gnt       ),
  .rvalid_i  ( sbr_rvalid    ),
  .mgr_req_i ( mgr_req_o.req ),
  .mgr_gnt_i ( mgr_rsp_i.gnt ),
  .pop_i     ( pop           ),
  .fault_i   ( fault_o       )
);

`default_nettype wire

/* tests/tb_obi_mux.sv */
/*
 * Directed tests of obi_mux against an in-order manager model. Reads return
 * the address XOR 32'hA5A5_A5A5 and writes return zero, never with err set.
 */
`timescale 1ns/100ps
`default_nettype none
`include "obi_mux_cfg.svh"

module tb_obi_mux;

  import obi_mux_pkg::*;

  localparam int unsigned n_ports = `OBI_NUM_PORTS;
  localparam logic [31:0] rd_mask = 32'hA5A5_A5A5;

  logic                   clk;
  logic                   rst_n;
  obi_req_t [n_ports-1:0] sbr_req = '0;
  obi_rsp_t [n_ports-1:0] sbr_rsp;
  obi_req_t               mgr_req;
  obi_rsp_t               mgr_rsp = '0;
  logic [1:0]             fault;

  obi_a_chan_t req_q [n_ports][$];
  logic [31:0] exp_q [n_ports][$];
  obi_a_chan_t pend_q [$];
  int unsigned gnt_log [$];
  logic        gnt_en = 1'b1;
  int unsigned gnt_rand = 0;
  int unsigned rsp_rand = 2;
  int          rsp_budget = 1000000;
  int          errors = 0;
  int          n_tests = 0;

  tb_clk_gen i_clk_gen (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  obi_mux uut (
    .clk_i     ( clk     ),
    .rst_n_i   ( rst_n   ),
    .sbr_req_i ( sbr_req ),
    .sbr_rsp_o ( sbr_rsp ),
    .mgr_req_o ( mgr_req ),
    .mgr_rsp_i ( mgr_rsp ),
    .fault_o   ( fault   )
  );

  task automatic report_mismatch(input string msg);
    $display("mismatch at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic report_failure(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    errors++;
  endtask

  // Subordinate drivers present queued requests and check what comes back.
  always @(posedge clk) begin
    for (int p = 0; p < n_ports; p++) begin
      if (sbr_req[p].req && sbr_rsp[p].gnt) begin
        if (mgr_req.a != sbr_req[p].a) begin
          report_mismatch($sformatf("port %0d A channel not forwarded", p));
        end
        exp_q[p].push_back(sbr_req[p].a.we ? 32'h0 : sbr_req[p].a.addr ^ rd_mask);
        gnt_log.push_back(p);
        void'(req_q[p].pop_front());
      end
      if (sbr_rsp[p].rvalid) begin
        if (exp_q[p].size() == 0) begin
          report_failure($sformatf("port %0d got a response it never requested", p));
        end else begin
          if (sbr_rsp[p].r.rdata != exp_q[p][0] || sbr_rsp[p].r.err) begin
            report_mismatch($sformatf("port %0d rdata %h err %b, expected %h err 0", p,
                                      sbr_rsp[p].r.rdata, sbr_rsp[p].r.err, exp_q[p][0]));
          end
          void'(exp_q[p].pop_front());
        end
      end
      sbr_req[p].req <= (req_q[p].size() != 0);
      if (req_q[p].size() != 0) begin
        sbr_req[p].a <= req_q[p][0];
      end
    end
    if (rst_n && fault != 2'b00) begin
      report_mismatch($sformatf("fault_o is %b, expected 00", fault));
    end
  end

  // Manager memory model, answering in order.
  always @(posedge clk) begin
    obi_a_chan_t head;
    if (mgr_rsp.rvalid) begin
      void'(pend_q.pop_front());
    end
    if (mgr_req.req && mgr_rsp.gnt) begin
      pend_q.push_back(mgr_req.a);
    end
    mgr_rsp.gnt    <= gnt_en && ($urandom % (gnt_rand + 1) == 0);
    mgr_rsp.rvalid <= 1'b0;
    if (pend_q.size() != 0 && rsp_budget > 0 && $urandom % (rsp_rand + 1) == 0) begin
      head = pend_q[0];
      mgr_rsp.rvalid  <= 1'b1;
      mgr_rsp.r.rdata <= head.we ? 32'h0 : head.addr ^ rd_mask;
      mgr_rsp.r.err   <= 1'b0;
      rsp_budget--;
    end
  end

  function automatic bit idle();
    bit busy;
    busy = (pend_q.size() != 0);
    for (int p = 0; p < n_ports; p++) begin
      busy = busy | (req_q[p].size() != 0) | (exp_q[p].size() != 0);
    end
    return !busy;
  endfunction

  task automatic enqueue(input int unsigned p, input bit we);
    obi_a_chan_t a;
    a.addr  = ($urandom & 32'hFFFF_FFF0) | (p << 2);
    a.wdata = $urandom;
    a.we    = we;
    a.be    = 4'hF;
    req_q[p].push_back(a);
  endtask

  task automatic wait_idle(input string what);
    int unsigned cycles;
    cycles = 0;
    while (!idle() && cycles < 3000) begin
      @(negedge clk);
      cycles++;
    end
    if (!idle()) begin
      report_failure({"timeout waiting for ", what, " to complete"});
    end
  endtask

  task automatic wait_grants(input int unsigned count);
    int unsigned cycles;
    cycles = 0;
    while (gnt_log.size() < count && cycles < 1000) begin
      @(negedge clk);
      cycles++;
    end
    if (gnt_log.size() < count) begin
      report_failure($sformatf("timeout waiting for %0d grants", count));
    end
  endtask

  task automatic print_result(input string name, input int start);
    n_tests++;
    $display("%s: %s", name, (errors == start) ? "ok" : "failed");
  endtask

  task automatic test_single_read();
    int start;
    start = errors;
    for (int unsigned p = 0; p < n_ports; p++) begin
      @(negedge clk);
      enqueue(p, 1'b0);
      wait_idle("single read");
    end
    print_result("single read per port", start);
  endtask

  task automatic test_round_robin();
    int start;
    int unsigned first;
    start = errors;
    first = (gnt_log.size() == 0) ? 0 : (gnt_log[$] + 1) % n_ports;
    @(negedge clk);
    gnt_log.delete();
    // Each port asks twice so that a rotating pointer interleaves the ports.
    for (int unsigned p = 0; p < n_ports; p++) begin
      enqueue(p, 1'b0);
      enqueue(p, 1'b0);
    end
    wait_idle("round robin");
    if (gnt_log.size() != 2 * n_ports) begin
      report_failure($sformatf("expected %0d grants, saw %0d", 2 * n_ports, gnt_log.size()));
    end else begin
      for (int unsigned i = 0; i < 2 * n_ports; i++) begin
        if (gnt_log[i] != (first + i) % n_ports) begin
          report_mismatch($sformatf("grant %0d went to port %0d, expected %0d", i,
                                    gnt_log[i], (first + i) % n_ports));
        end
      end
    end
    print_result("round-robin order", start);
  endtask

  task automatic test_lock_in();
    int start;
    int unsigned ptr;
    int unsigned lock_port;
    start = errors;
    ptr = (gnt_log.size() == 0) ? 0 : (gnt_log[$] + 1) % n_ports;
    lock_port = (ptr + 2) % n_ports;
    @(negedge clk);
    gnt_log.delete();
    gnt_en = 1'b0;
    enqueue(lock_port, 1'b0);
    repeat (2) @(negedge clk);
    // The pointer port now outranks the waiting one in a fresh search.
    enqueue(ptr, 1'b0);
    repeat (6) begin
      @(negedge clk);
      if (!mgr_req.req || mgr_req.a != sbr_req[lock_port].a) begin
        report_mismatch($sformatf("selection left port %0d before its grant", lock_port));
      end
    end
    gnt_en = 1'b1;
    wait_idle("lock-in");
    if (gnt_log.size() == 0 || gnt_log[0] != lock_port) begin
      report_mismatch($sformatf("first grant not to locked port %0d", lock_port));
    end
    print_result("lock-in", start);
  endtask

  task automatic test_back_pressure();
    int start;
    start = errors;
    @(negedge clk);
    gnt_log.delete();
    rsp_budget = 0;
    for (int unsigned p = 0; p < n_ports; p++) begin
      enqueue(p, 1'b0);
      enqueue(p, 1'b1);
    end
    wait_grants(`OBI_MAX_TRANS);
    repeat (8) begin
      @(negedge clk);
      if (mgr_req.req) begin
        report_failure("manager request raised while the FIFO is full");
      end
      for (int unsigned p = 0; p < n_ports; p++) begin
        if (sbr_rsp[p].gnt) begin
          report_failure($sformatf("port %0d granted while the FIFO is full", p));
        end
      end
    end
    if (gnt_log.size() != `OBI_MAX_TRANS) begin
      report_mismatch($sformatf("%0d grants while stalled", gnt_log.size()));
    end
    rsp_budget = 1;
    wait_grants(`OBI_MAX_TRANS + 1);
    repeat (8) @(negedge clk);
    if (gnt_log.size() != `OBI_MAX_TRANS + 1) begin
      report_mismatch($sformatf("%0d grants after one response", gnt_log.size()));
    end
    rsp_budget = 1000000;
    wait_idle("back-pressure");
    print_result("back-pressure", start);
  endtask

  task automatic test_random_traffic();
    int start;
    start = errors;
    gnt_rand = 2;
    rsp_rand = 3;
    for (int c = 0; c < 300; c++) begin
      @(negedge clk);
      for (int unsigned p = 0; p < n_ports; p++) begin
        if (req_q[p].size() < 2 && $urandom % 4 == 0) begin
          enqueue(p, ($urandom % 2) == 1);
        end
      end
    end
    wait_idle("random traffic");
    gnt_rand = 0;
    print_result("mixed random traffic", start);
  endtask

  initial begin
    void'($urandom(32'h31b5_63d1));
    for (int i = 0; i < 100 && !rst_n; i++) begin
      @(negedge clk);
    end
    if (!rst_n) begin
      report_failure("reset was never released");
    end
    @(negedge clk);
    if (mgr_req.req || fault != 2'b00 || !uut.fifo_empty) begin
      report_mismatch("outputs or FIFO not idle after reset");
    end
    for (int unsigned p = 0; p < n_ports; p++) begin
      if (sbr_rsp[p].gnt || sbr_rsp[p].rvalid) begin
        report_mismatch($sformatf("port %0d gnt or rvalid set after reset", p));
      end
    end
    test_single_read();
    test_round_robin();
    test_lock_in();
    test_back_pressure();
    test_random_traffic();
    $display("tests run %0d, errors %0d", n_tests, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+source
source/obi_mux_pkg.sv
source/obi_rr_arbiter.sv
source/id_ecc_fifo.sv
source/obi_rsp_router.sv
source/obi_mux.sv
tests/tb_clk_gen.sv
tests/obi_mux_asserts.sv
tests/tb_obi_mux.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the obi_mux testbench with Verilator from the project root.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_obi_mux \
  -f project.f -o tb_obi_mux > build.log 2>&1 ||
{ cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_obi_mux > sim.log 2>&1 || echo "** FAIL **" >> sim.log
cat sim.log
grep -q "\*\* FAIL \*\*" sim.log && { echo "simulation failed"; exit 1; } || echo "simulation passed"
